// ==== design/tx_pack.sv ====
// Shared widths, types and PRBS constants for the serializing TX lane

package tx_pack;

    // Datapath widths
    localparam int word_w = 16;    // Parallel word from the source
    localparam int nib_w  = 4;     // Quarter-rate lane width
    localparam int cnt_w  = 4;     // Bit-time counter, one word period

    typedef logic [word_w-1:0] word_t;
    typedef logic [nib_w-1:0]  nib_t;

    // PRBS-15, x^15 + x^14 + 1
    localparam int prbs_len = 15;
    // Tap mask on state bits 14 and 13, XOR of the masked bits is the feedback
    localparam logic [prbs_len-1:0] prbs_poly = 15'h6000;
    localparam logic [prbs_len-1:0] prbs_seed = '1;    // Any nonzero value works

    // Edges from the word capture edge to the first bit on dout_p
    //   +4  first nibble into the QR stage, MSB straight into the retime flop
    //   +5  driver register
    localparam int first_bit_lat = 5;

endpackage

// ==== design/tx_clk_ctrl.sv ====
`timescale 1ns/1ns

`default_nettype none

// Replaces the divider chain, all strobes come from one bit-time counter
module tx_clk_ctrl import tx_pack::*; (
    input  wire logic mdll_clk,    // Bit-rate clock
    input  wire logic rst,
    input  wire logic en_tx,       // Lane enable
    output logic      word_ld,     // One pulse per 16 bit times
    output logic      nib_ld,      // One pulse per 4 bit times
    output logic      drv_en       // Driver on, level
);

    logic [cnt_w-1:0] cnt;         // Bit time within the word
    logic [cnt_w-1:0] dly;         // Edges since the first word capture
    logic             drv_on;      // First valid bit has reached the driver

    // Held at 0 while disabled so the first word always lands at count 15
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (!en_tx) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;                  // Wraps at 15
        end
    end

    // Word capture on the last bit time of the period
    assign word_ld = en_tx & (&cnt);

    // Nibble load every fourth bit time, lines up with word_ld at count 15
    assign nib_ld = en_tx & (&cnt[1:0]);

    // Start delay, begins on the first word_ld after enable
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            dly    <= '0;
            drv_on <= 1'b0;
        end else if (!en_tx) begin
            dly    <= '0;
            drv_on <= 1'b0;
        end else if (!drv_on) begin
            if (word_ld || dly != '0) begin
                dly <= dly + 1'b1;
            end
            // dly reaches first_bit_lat on edge E+4, driver turns on at E+5
            if (dly == cnt_w'(first_bit_lat)) begin
                drv_on <= 1'b1;
            end
        end
    end

    // Driver follows en_tx down without waiting for a clock
    assign drv_en = drv_on & en_tx;

    // Last nibble of a word must move on the same edge that captures the next word
    a_word_ld_nib_ld: assert property (
        @(posedge mdll_clk) disable iff (rst)
        word_ld |-> nib_ld
    ) else $error("word_ld without nib_ld");

endmodule

`default_nettype wire

// ==== design/prbs_gen16.sv ====
`timescale 1ns/1ns

`default_nettype none

// Word source, either external data or sixteen PRBS-15 bits per word
module prbs_gen16 import tx_pack::*; (
    input  wire logic  mdll_clk,
    input  wire logic  rst,
    input  wire logic  word_ld,     // Advance to the next word
    input  wire logic  use_prbs,    // 1 selects the internal PRBS
    input  wire word_t din,         // External word
    output word_t      word         // To the half-rate stage
);

    logic [prbs_len-1:0] lfsr;      // Fibonacci state
    logic [prbs_len-1:0] lfsr_nxt;  // State sixteen steps on
    logic [prbs_len-1:0] stp;       // Walking state in the unroll
    logic                fb;        // Feedback bit of one step
    word_t               prbs_word; // Bits of the next sixteen steps

    // Sixteen LFSR steps unrolled, first bit produced goes to the MSB
    always_comb begin
        stp = lfsr;
        fb  = 1'b0;
        for (int i = 0; i < word_w; i++) begin
            fb                     = ^(stp & prbs_poly);
            prbs_word[word_w-1-i]  = fb;
            stp                    = {stp[prbs_len-2:0], fb};
        end
        lfsr_nxt = stp;
    end

    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            lfsr <= prbs_seed;
        end else if (word_ld) begin
            lfsr <= lfsr_nxt;               // Current word consumed this edge
        end
    end

    assign word = use_prbs ? prbs_word : din;

    // All-zero state would lock the generator
    a_lfsr_nonzero: assert property (
        @(posedge mdll_clk) disable iff (rst)
        lfsr != '0
    ) else $error("PRBS state is zero");

endmodule

`default_nettype wire

// ==== design/hr_16t4_mux.sv ====
`timescale 1ns/1ns

`default_nettype none

// Half-rate 16 to 4 stage, stores the word in lane-interleaved order
module hr_16t4_mux import tx_pack::*; (
    input  wire logic  mdll_clk,
    input  wire logic  rst,
    input  wire logic  word_ld,     // Capture a new word
    input  wire logic  nib_ld,      // QR stage takes the current nibble
    input  wire word_t word,
    output nib_t       nib          // Nibble presented to the QR stage
);

    localparam int n_lane = word_w / nib_w;    // 4 lanes, each nib_w bits

    word_t      ilv;                // Reordered input
    word_t      word_r;             // Captured word, interleaved
    logic [1:0] idx;                // Nibble in flight, 0 goes first
    logic [1:0] pos;                // Lane bit position for idx

    // Lane j holds bits 15-j, 7-j, 11-j, 3-j at positions 0..3
    always_comb begin
        for (int j = 0; j < n_lane; j++) begin
            ilv[nib_w*j + 0] = word[word_w - 1 - j];
            ilv[nib_w*j + 1] = word[word_w/2 - 1 - j];
            ilv[nib_w*j + 2] = word[3*word_w/4 - 1 - j];
            ilv[nib_w*j + 3] = word[word_w/4 - 1 - j];
        end
    end

    always_ff @(posedge mdll_clk) begin
        if (word_ld) begin
            word_r <= ilv;
        end
    end

    // Index restarts with each word, otherwise steps per nibble load
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            idx <= '0;
        end else if (word_ld) begin
            idx <= '0;
        end else if (nib_ld) begin
            idx <= idx + 1'b1;
        end
    end

    // Lane position is the bit-reversed index, so positions run 0, 2, 1, 3
    assign pos = {idx[0], idx[1]};

    // One bit per lane, lane 0 carries the earliest bit of the nibble
    always_comb begin
        for (int j = 0; j < nib_w; j++) begin
            nib[j] = word_r[nib_w*j + pos];
        end
    end

endmodule

`default_nettype wire

// ==== design/qr_4t1_mux.sv ====
`timescale 1ns/1ns

`default_nettype none

// Quarter-rate 4 to 1 stage with a retiming flop on the serial output
module qr_4t1_mux import tx_pack::*; (
    input  wire logic mdll_clk,
    input  wire logic rst,
    input  wire logic nib_ld,       // Take a new nibble
    input  wire nib_t nib,          // nib[0] is the earliest bit
    output logic      bit_out       // Serial bit, one per clock
);

    logic [nib_w-2:0] sr;           // Bits still waiting after the first
    logic [nib_w-2:0] sr_ld;        // Remaining bits, MSB goes out next
    logic             retime;       // Output flop

    // Un-interleave, nib[1] leaves first from the shift register
    always_comb begin
        for (int i = 0; i < nib_w - 1; i++) begin
            sr_ld[nib_w-2-i] = nib[i+1];
        end
    end

    always_ff @(posedge mdll_clk) begin
        if (nib_ld) begin
            sr <= sr_ld;
        end else begin
            sr <= {sr[nib_w-3:0], 1'b0};    // Shift every bit time
        end
    end

    // First bit of a nibble bypasses the shift register, no gap at the seam
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            retime <= 1'b0;
        end else begin
            retime <= nib_ld ? nib[0] : sr[nib_w-2];
        end
    end

    assign bit_out = retime;

    // Back-to-back loads would drop the rest of a nibble
    a_nib_ld_spacing: assert property (
        @(posedge mdll_clk) disable iff (rst)
        nib_ld |=> !nib_ld
    ) else $error("nib_ld on consecutive cycles");

endmodule

`default_nettype wire

// ==== design/output_buf_tx.sv ====
`timescale 1ns/1ns

`default_nettype none

// Differential driver, registered data with optional polarity swap
module output_buf_tx (
    input  wire logic mdll_clk,
    input  wire logic rst,
    input  wire logic bit_in,       // Serial bit from the QR stage
    input  wire logic drv_en,       // Driver on
    input  wire logic invert,       // Swap line polarity
    output logic      dout_p,
    output logic      dout_n
);

    logic q;                        // Driver data flop

    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            q <= 1'b0;
        end else begin
            q <= bit_in ^ invert;
        end
    end

    // Both legs idle low when off
    assign dout_p = drv_en ? q  : 1'b0;
    assign dout_n = drv_en ? ~q : 1'b0;

    a_diff_pair: assert property (
        @(posedge mdll_clk) disable iff (rst)
        drv_en |-> (dout_p != dout_n)
    ) else $error("dout_p and dout_n equal while enabled");

endmodule

`default_nettype wire

// ==== design/tx_top.sv ====
`timescale 1ns/1ns

`default_nettype none

// TX lane, source -> 16:4 -> 4:1 -> driver, all on one bit-rate clock
module tx_top import tx_pack::*; (
    input  wire logic  mdll_clk,    // Bit-rate clock, stands in for the PI phases
    input  wire logic  rst,         // Global TX reset
    input  wire word_t din,         // External word, valid while word_strobe is high
    input  wire logic  use_prbs,
    input  wire logic  en_tx,
    input  wire logic  invert,
    output logic       word_strobe, // Word request to the external source
    output logic       dout_p,
    output logic       dout_n
);

    logic  word_ld;
    logic  nib_ld;
    logic  drv_en;
    word_t src_word;                // Source to half-rate stage
    nib_t  qr_nib;                  // Half-rate to quarter-rate stage
    logic  ser_bit;                 // QR stage to driver

    tx_clk_ctrl u_ctrl (
        .mdll_clk (mdll_clk),
        .rst      (rst),
        .en_tx    (en_tx),
        .word_ld  (word_ld),
        .nib_ld   (nib_ld),
        .drv_en   (drv_en)
    );

    prbs_gen16 u_src (
        .mdll_clk (mdll_clk),
        .rst      (rst),
        .word_ld  (word_ld),
        .use_prbs (use_prbs),
        .din      (din),
        .word     (src_word)
    );

    hr_16t4_mux u_hr (
        .mdll_clk (mdll_clk),
        .rst      (rst),
        .word_ld  (word_ld),
        .nib_ld   (nib_ld),
        .word     (src_word),
        .nib      (qr_nib)
    );

    qr_4t1_mux u_qr (
        .mdll_clk (mdll_clk),
        .rst      (rst),
        .nib_ld   (nib_ld),
        .nib      (qr_nib),
        .bit_out  (ser_bit)
    );

    output_buf_tx u_buf (
        .mdll_clk (mdll_clk),
        .rst      (rst),
        .bit_in   (ser_bit),
        .drv_en   (drv_en),
        .invert   (invert),
        .dout_p   (dout_p),
        .dout_n   (dout_n)
    );

    assign word_strobe = word_ld;   // Plays the part of clk_prbsgen

endmodule

`default_nettype wire

// ==== tb/tx_tb.sv ====
`timescale 1ns/1ns

// Serial lane testbench with a queued word model and a falling-edge bit checker
module tx_tb import tx_pack::*; ();

    localparam int n_words     = 20;       // Words per test phase
    localparam int rst_cyc     = 16;
    localparam int idle_cyc    = 8;        // Lane-off gap around enable changes
    // Twice the length of three phases with drain words and idle gaps
    localparam int timeout_cyc = 2 * (rst_cyc + 2 * idle_cyc + (3 * n_words + 6) * word_w);

    logic  mdll_clk = 1'b0;
    logic  rst;
    word_t din;
    logic  use_prbs;
    logic  en_tx;
    logic  invert;
    logic  word_strobe;
    logic  dout_p;
    logic  dout_n;

    integer              seed = 54;
    int                  cyc = 0;           // Rising edges so far
    int                  last_strobe = -1;  // Cycle of the previous strobe or -1 before the first
    int                  pushed = 0;        // Words handed to the DUT
    int                  words_chk = 0;     // Words fully compared on dout_p
    int                  bit_idx;
    int                  base;
    logic                strobed;           // Last step saw word_strobe
    logic [prbs_len-1:0] model_lfsr = prbs_seed;
    word_t               rx_word;           // Bits collected from dout_p
    word_t               exp_q[$];          // Expected line words with invert applied
    int                  start_q[$];        // Cycle of each word's first bit

    tx_top u_dut (
        .mdll_clk    (mdll_clk),
        .rst         (rst),
        .din         (din),
        .use_prbs    (use_prbs),
        .en_tx       (en_tx),
        .invert      (invert),
        .word_strobe (word_strobe),
        .dout_p      (dout_p),
        .dout_n      (dout_n)
    );

    initial begin
        forever #5 mdll_clk = ~mdll_clk;
    end

    // Cycle count and run limit
    always @(posedge mdll_clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cyc) begin
            $display("Run did not finish within %0d cycles", timeout_cyc);
            fail_stop();
        end
    end

    task automatic fail_stop();
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            fail_stop();
        end
    endtask

    // Sixteen steps of x^15 + x^14 + 1 with the earliest bit in the MSB
    function automatic word_t prbs_next_word();
        word_t w;
        logic  fb;
        w = '0;
        for (int i = 0; i < word_w; i++) begin
            fb         = model_lfsr[prbs_len-1] ^ model_lfsr[prbs_len-2];
            w          = {w[word_w-2:0], fb};
            model_lfsr = {model_lfsr[prbs_len-2:0], fb};
        end
        return w;
    endfunction

    // Advance one cycle and answer a strobe with a new word 1 ns after the edge
    task automatic step();
        word_t nxt;
        @(posedge mdll_clk);
        #1;
        strobed = word_strobe;
        if (word_strobe && last_strobe >= 0 && cyc - last_strobe != word_w) begin
            $display("word_strobe came %0d cycles after the previous one instead of %0d",
                     cyc - last_strobe, word_w);
            fail_stop();
        end else if (word_strobe) begin
            last_strobe = cyc;
            nxt = prbs_next_word();             // DUT LFSR steps on every strobe
            if (!use_prbs) begin
                din = word_t'($random(seed));
                nxt = din;
            end
            exp_q.push_back(nxt ^ {word_w{invert}});
            start_q.push_back(cyc + 1 + first_bit_lat);  // Capture edge is the next one
            pushed++;
        end
    endtask

    // Ends on a cycle without a strobe so modes can change safely
    task automatic run_words(input int n);
        int target;
        target = pushed + n;
        while (pushed < target) begin
            step();
        end
        step();
    endtask

    task automatic drain(input int target);
        while (words_chk < target || strobed) begin
            step();
        end
    endtask

    // Output checker on the falling edge clear of clock and input changes
    always @(negedge mdll_clk) begin
        if (!en_tx) begin
            check_bit("word_strobe", word_strobe, 1'b0);
        end
        if (exp_q.size() != 0 && cyc >= start_q[0]) begin
            bit_idx = cyc - start_q[0];
            check_bit("dout_n", dout_n, ~dout_p);        // Differential pair
            rx_word = {rx_word[word_w-2:0], dout_p};     // MSB arrives first
            if (bit_idx == word_w - 1) begin
                check_word("dout_p word", rx_word, exp_q[0]);
                void'(exp_q.pop_front());
                void'(start_q.pop_front());
                words_chk++;
            end
        end else begin
            // Driver idles low while no word is due
            check_bit("dout_p", dout_p, 1'b0);
            check_bit("dout_n", dout_n, 1'b0);
        end
    end

    initial begin
        rst      = 1'b1;
        din      = '0;
        use_prbs = 1'b0;
        en_tx    = 1'b0;
        invert   = 1'b0;
        strobed  = 1'b0;
        rx_word  = '0;
        repeat (rst_cyc) step();
        rst = 1'b0;
        repeat (idle_cyc) step();              // Lane still off after reset

        // External random words
        en_tx = 1'b1;
        run_words(n_words);

        // PRBS words switched in between strobes
        use_prbs = 1'b1;
        run_words(n_words);
        drain(2 * n_words);

        // Outputs drop without a clock when the lane goes off
        en_tx = 1'b0;
        #1;
        check_bit("dout_p", dout_p, 1'b0);
        check_bit("dout_n", dout_n, 1'b0);
        exp_q.delete();                        // In-flight words never reach the line
        start_q.delete();
        last_strobe = -1;
        invert      = 1'b1;
        use_prbs    = 1'b0;
        repeat (idle_cyc) step();

        // Restart with inverted external words on the new alignment
        en_tx = 1'b1;
        base  = words_chk;
        run_words(n_words);
        drain(base + n_words);

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== src.f ====
design/tx_pack.sv
design/tx_clk_ctrl.sv
design/prbs_gen16.sv
design/hr_16t4_mux.sv
design/qr_4t1_mux.sv
design/output_buf_tx.sv
design/tx_top.sv
tb/tx_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the TX lane testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 \
    --top-module tx_tb \
    -f src.f \
    -o tx_sim &&
./obj_dir/tx_sim || exit 1
